// File: source/tcb_pkg.sv
////////////////////////////////////////////////////////////
// TCB package
// bus widths, address map and the request and response
// structs shared by the decoder and both subordinates
////////////////////////////////////////////////////////////

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_AW = 16;
  // data width
  localparam int unsigned TCB_DW = 32;
  // one enable per data byte
  localparam int unsigned TCB_BW = TCB_DW / 8;

  // response follows the transfer edge by this many cycles
  // RTL is built for exactly one, the decoder select is a single stage
  localparam int unsigned TCB_DLY = 1;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // sram word index width, 256 words
  localparam int unsigned SRAM_AW = 8;

  // region number taken from address bits 15:12
  localparam logic [3:0] MAP_SRAM = 4'd0;
  localparam logic [3:0] MAP_GPIO = 4'd1;

  // gpio register byte offsets within the region
  localparam logic [11:0] GPIO_DRIVE_OFS = 12'h000;
  localparam logic [11:0] GPIO_SENSE_OFS = 12'h004;

  ////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              wen;  // write enable
    logic [TCB_AW-1:0] adr;  // byte address
    logic [TCB_BW-1:0] ben;  // byte enables
    logic [TCB_DW-1:0] wdt;  // write data
  } tcb_req_t;

  typedef struct packed {
    logic [TCB_DW-1:0] rdt;  // read data, zero for writes
    logic              err;  // error
  } tcb_rsp_t;

endpackage

// File: source/tcb_dec.sv
////////////////////////////////////////////////////////////
// TCB address decoder
// steers one manager port to the sram or the gpio block,
// answers unmapped regions itself with an error response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_dec (
  input  logic              bus,
  input  logic              arst_n,
  // manager port
  input  tcb_pkg::tcb_req_t man_req,
  input  logic              man_vld,
  output logic              man_rdy,
  output tcb_pkg::tcb_rsp_t man_rsp,
  // sram subordinate
  output logic              sram_vld,
  input  logic              sram_rdy,
  input  tcb_pkg::tcb_rsp_t sram_rsp,
  // gpio subordinate
  output logic              gpio_vld,
  input  logic              gpio_rdy,
  input  tcb_pkg::tcb_rsp_t gpio_rsp,
  // request broadcast to both
  output tcb_pkg::tcb_req_t sub_req
);
  import tcb_pkg::*;

  // region field of the request
  logic [3:0] region;
  logic       hit_sram;
  logic       hit_gpio;
  logic       hit_none;

  // transfer on the manager port
  logic trn;

  // select of the response in flight
  logic sel_sram;
  logic sel_gpio;
  logic err_pend;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  assign region   = man_req.adr[TCB_AW-1:TCB_AW-4];
  assign hit_sram = (region == MAP_SRAM);
  assign hit_gpio = (region == MAP_GPIO);
  assign hit_none = ~hit_sram & ~hit_gpio;

  // same request everywhere, only vld is gated
  assign sub_req  = man_req;
  assign sram_vld = man_vld & hit_sram;
  assign gpio_vld = man_vld & hit_gpio;

  // unmapped access never stalls
  assign man_rdy = hit_sram ? sram_rdy : (hit_gpio ? gpio_rdy : 1'b1);
  assign trn     = man_vld & man_rdy;

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  // region of the last transfer, one stage matches TCB_DLY
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      sel_sram <= 1'b0;
      sel_gpio <= 1'b0;
      err_pend <= 1'b0;
    end else if (trn) begin
      sel_sram <= hit_sram;
      sel_gpio <= hit_gpio;
      err_pend <= hit_none;
    end
  end

  always_comb begin
    if (sel_sram) begin
      man_rsp = sram_rsp;
    end else if (sel_gpio) begin
      man_rsp = gpio_rsp;
    end else begin
      // error region, zero data
      man_rsp.rdt = '0;
      man_rsp.err = err_pend;
    end
  end

endmodule

// File: source/tcb_sram.sv
////////////////////////////////////////////////////////////
// TCB SRAM subordinate
// 256 word memory with byte enables, reads take one wait
// state so the array output is registered
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_sram (
  input  logic              bus,
  input  logic              arst_n,
  input  tcb_pkg::tcb_req_t req,
  input  logic              vld,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);
  import tcb_pkg::*;

  // word array
  logic [TCB_DW-1:0] mem [0:(1<<SRAM_AW)-1];

  // word index and range check
  logic [SRAM_AW-1:0] idx;
  logic               oor;

  // read wait state
  logic rd;
  logic wait_q;
  logic trn;

  // registered array output
  logic [TCB_DW-1:0] mem_rdt;

  assign idx = req.adr[SRAM_AW+1:2];
  // anything at or past 1 KiB inside the region
  assign oor = |req.adr[TCB_AW-5:SRAM_AW+2];

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  assign rd  = vld & ~req.wen;
  // writes go through at once, reads on the second cycle
  assign rdy = ~rd | wait_q;
  assign trn = vld & rdy;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wait_q <= 1'b0;
    end else begin
      // set on first read cycle, clear once it transfers
      wait_q <= rd & ~wait_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (trn && req.wen && !oor) begin
      for (int i = 0; i < TCB_BW; i++) begin
        if (req.ben[i]) mem[idx][8*i +: 8] <= req.wdt[8*i +: 8];
      end
    end
    // sync read, valid during the wait cycle
    mem_rdt <= mem[idx];
  end

  // response loads on the transfer edge
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else if (trn) begin
      rsp.rdt <= (req.wen || oor) ? '0 : mem_rdt;
      rsp.err <= oor;
    end
  end

endmodule

// File: source/tcb_gpio.sv
////////////////////////////////////////////////////////////
// TCB GPIO subordinate
// drive register out to the pins, synchronized sense
// register in, error on any other access
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_gpio (
  input  logic                      bus,
  input  logic                      arst_n,
  input  tcb_pkg::tcb_req_t         req,
  input  logic                      vld,
  output logic                      rdy,
  output tcb_pkg::tcb_rsp_t         rsp,
  // pins
  output logic [tcb_pkg::TCB_DW-1:0] pin_drive,
  input  logic [tcb_pkg::TCB_DW-1:0] pin_sense
);
  import tcb_pkg::*;

  // register decode
  logic [11:0] ofs;
  logic        acc_drive;
  logic        acc_sense;
  logic        bad;
  logic        trn;

  // two flop synchronizer, sense_q is the readable copy
  logic [TCB_DW-1:0] sense_m;
  logic [TCB_DW-1:0] sense_q;

  assign ofs       = req.adr[11:0];
  assign acc_drive = (ofs == GPIO_DRIVE_OFS);
  assign acc_sense = (ofs == GPIO_SENSE_OFS);
  // sense is read only, other offsets unmapped
  assign bad       = ~(acc_drive | (acc_sense & ~req.wen));

  // no wait states
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      pin_drive <= '0;
    end else if (trn && req.wen && acc_drive) begin
      for (int i = 0; i < TCB_BW; i++) begin
        if (req.ben[i]) pin_drive[8*i +: 8] <= req.wdt[8*i +: 8];
      end
    end
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      sense_m <= '0;
      sense_q <= '0;
    end else begin
      sense_m <= pin_sense;
      sense_q <= sense_m;
    end
  end

  // response, data only for legal reads
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else if (trn) begin
      rsp.err <= bad;
      if (req.wen || bad) rsp.rdt <= '0;
      else                rsp.rdt <= acc_drive ? pin_drive : sense_q;
    end
  end

endmodule

// File: source/tcb_sys.sv
////////////////////////////////////////////////////////////
// TCB subsystem top
// one manager port decoded to sram and gpio subordinates
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_sys (
  input  logic                       bus,
  input  logic                       arst_n,
  // manager port
  input  tcb_pkg::tcb_req_t          req,
  input  logic                       vld,
  output logic                       rdy,
  output tcb_pkg::tcb_rsp_t          rsp,
  // gpio pins
  output logic [tcb_pkg::TCB_DW-1:0] pin_drive,
  input  logic [tcb_pkg::TCB_DW-1:0] pin_sense
);
  import tcb_pkg::*;

  // shared request, per subordinate handshake
  tcb_req_t sub_req;
  logic     sram_vld;
  logic     sram_rdy;
  tcb_rsp_t sram_rsp;
  logic     gpio_vld;
  logic     gpio_rdy;
  tcb_rsp_t gpio_rsp;

  tcb_dec dec0 (
    .bus, .arst_n,
    .man_req (req),     .man_vld (vld),     .man_rdy (rdy),     .man_rsp (rsp),
    .sram_vld, .sram_rdy, .sram_rsp,
    .gpio_vld, .gpio_rdy, .gpio_rsp,
    .sub_req
  );

  tcb_sram sram0 (
    .bus, .arst_n,
    .req (sub_req), .vld (sram_vld), .rdy (sram_rdy), .rsp (sram_rsp)
  );

  tcb_gpio gpio0 (
    .bus, .arst_n,
    .req (sub_req), .vld (gpio_vld), .rdy (gpio_rdy), .rsp (gpio_rsp),
    .pin_drive, .pin_sense
  );

endmodule

// File: test/tcb_clk.sv
////////////////////////////////////////////////////////////
// TCB testbench clock
// free running bus clock and a reset held for 4 cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_clk (
  output logic bus,
  output logic arst_n
);

  // 8 ns period
  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  // release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge bus);
    @(negedge bus);
    arst_n = 1'b1;
  end

endmodule

// File: test/tcb_sys_tb.sv
////////////////////////////////////////////////////////////
// TCB subsystem testbench
// directed tests of sram, gpio and decoder error paths
// against a reference model of memory and drive register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_sys_tb;
  import tcb_pkg::*;

  logic              bus;
  logic              arst_n;
  tcb_req_t          req;
  logic              vld;
  logic              rdy;
  tcb_rsp_t          rsp;
  logic [TCB_DW-1:0] pin_drive;
  logic [TCB_DW-1:0] pin_sense;

  // reference model
  logic [TCB_DW-1:0]  ref_mem [0:(1<<SRAM_AW)-1];
  logic [TCB_DW-1:0]  drive_ref = '0;
  // words touched by the round trip
  logic [SRAM_AW-1:0] sram_words [0:15];
  // galois lfsr state
  logic [15:0]        lfsr_state = 16'd40782;

  tcb_clk clk0 (.bus, .arst_n);

  tcb_sys dut0 (
    .bus, .arst_n, .req, .vld, .rdy, .rsp, .pin_drive, .pin_sense
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
    end
    return val;
  endfunction

  // byte enable merge
  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wdt,
                                        input logic [3:0] ben);
    logic [31:0] val;
    val = old;
    for (int i = 0; i < 4; i++) begin
      if (ben[i]) val[8*i +: 8] = wdt[8*i +: 8];
    end
    return val;
  endfunction

  function automatic tcb_req_t make_req(input logic wen, input logic [15:0] adr,
                                        input logic [3:0] ben, input logic [31:0] wdt);
    tcb_req_t r;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t while waiting for %s", $time, what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // rdy sampled inside the cycle, returns on the transfer edge
  task automatic wait_transfer();
    int unsigned cnt;
    logic        seen;
    cnt = 0;
    seen = 1'b0;
    while (!seen) begin
      #1;
      seen = rdy;
      @(posedge bus);
      cnt++;
      if (!seen && cnt >= 16) report_timeout("rdy");
    end
  endtask

  // single transfer, idle before and after
  task automatic access(input tcb_req_t r, output tcb_rsp_t got);
    @(negedge bus);
    req = r;
    vld = 1'b1;
    wait_transfer();
    // response one cycle after the transfer
    repeat (TCB_DLY) @(negedge bus);
    got = rsp;
    vld = 1'b0;
  endtask

  task automatic write_word(input logic [15:0] adr, input logic [3:0] ben,
                            input logic [31:0] wdt, input logic exp_err);
    tcb_rsp_t got;
    access(make_req(1'b1, adr, ben, wdt), got);
    check("rsp.err", got.err, exp_err);
    check("rsp.rdt", got.rdt, '0);
  endtask

  task automatic read_word(input logic [15:0] adr, input logic [31:0] exp_rdt,
                           input logic exp_err);
    tcb_rsp_t got;
    access(make_req(1'b0, adr, 4'hf, '0), got);
    check("rsp.err", got.err, exp_err);
    check("rsp.rdt", got.rdt, exp_rdt);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic sram_round_trip();
    logic [31:0]        tmp;
    logic [SRAM_AW-1:0] w;
    logic [3:0]         ben;
    for (int i = 0; i < 16; i++) begin
      // one word out of each block of 16
      tmp = rand_bits(4);
      w = {i[3:0], tmp[3:0]};
      sram_words[i] = w;
      tmp = rand_bits(32);
      ref_mem[w] = tmp;
      write_word({6'b0, w, 2'b00}, 4'hf, tmp, 1'b0);
      ben = rand_bits(4);
      tmp = rand_bits(32);
      ref_mem[w] = merge(ref_mem[w], tmp, ben);
      write_word({6'b0, w, 2'b00}, ben, tmp, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      read_word({6'b0, sram_words[i], 2'b00}, ref_mem[sram_words[i]], 1'b0);
    end
  endtask

  // vld held high, responses come back in order
  task automatic back_to_back();
    tcb_req_t           ops [0:8];
    logic [31:0]        exp_rdt [0:8];
    logic [SRAM_AW-1:0] w;
    for (int k = 0; k < 4; k++) begin
      w = sram_words[rand_bits(4)];
      ops[2*k] = make_req(1'b1, {6'b0, w, 2'b00}, rand_bits(4), rand_bits(32));
      ref_mem[w] = merge(ref_mem[w], ops[2*k].wdt, ops[2*k].ben);
      exp_rdt[2*k] = '0;
      ops[2*k+1] = make_req(1'b0, {6'b0, w, 2'b00}, 4'hf, '0);
      exp_rdt[2*k+1] = ref_mem[w];
    end
    // last one switches the select over to gpio
    ops[8] = make_req(1'b0, {MAP_GPIO, GPIO_DRIVE_OFS}, 4'hf, '0);
    exp_rdt[8] = drive_ref;
    @(negedge bus);
    req = ops[0];
    vld = 1'b1;
    for (int i = 0; i < 9; i++) begin
      wait_transfer();
      @(negedge bus);
      // next request already on the bus while this response is checked
      if (i < 8) begin
        req = ops[i+1];
      end else begin
        vld = 1'b0;
      end
      #1;
      check("rsp.err", rsp.err, 1'b0);
      check("rsp.rdt", rsp.rdt, exp_rdt[i]);
    end
  endtask

  task automatic gpio_drive();
    logic [31:0] data;
    data = rand_bits(32);
    drive_ref = merge(drive_ref, data, 4'b0101);
    write_word({MAP_GPIO, GPIO_DRIVE_OFS}, 4'b0101, data, 1'b0);
    check("pin_drive", pin_drive, drive_ref);
    read_word({MAP_GPIO, GPIO_DRIVE_OFS}, drive_ref, 1'b0);
    data = rand_bits(32);
    drive_ref = merge(drive_ref, data, 4'b1010);
    write_word({MAP_GPIO, GPIO_DRIVE_OFS}, 4'b1010, data, 1'b0);
    check("pin_drive", pin_drive, drive_ref);
    read_word({MAP_GPIO, GPIO_DRIVE_OFS}, drive_ref, 1'b0);
  endtask

  task automatic gpio_sense();
    @(negedge bus);
    pin_sense = rand_bits(32);
    // read goes out three cycles after the pin change
    repeat (2) @(negedge bus);
    read_word({MAP_GPIO, GPIO_SENSE_OFS}, pin_sense, 1'b0);
  endtask

  task automatic error_responses();
    logic [31:0] data;
    data = rand_bits(32);
    ref_mem[0] = data;
    write_word(16'h0000, 4'hf, data, 1'b0);
    // unmapped region
    write_word(16'h2000, 4'hf, rand_bits(32), 1'b1);
    read_word(16'h2000, '0, 1'b1);
    // 0x0400 would alias word 0
    write_word(16'h0400, 4'hf, ~data, 1'b1);
    read_word(16'h0400, '0, 1'b1);
    read_word(16'h0000, ref_mem[0], 1'b0);
    // sense is read only
    write_word({MAP_GPIO, GPIO_SENSE_OFS}, 4'hf, ~pin_sense, 1'b1);
    read_word({MAP_GPIO, GPIO_SENSE_OFS}, pin_sense, 1'b0);
    // nothing at offset 8
    write_word({MAP_GPIO, 12'h008}, 4'hf, ~drive_ref, 1'b1);
    read_word({MAP_GPIO, 12'h008}, '0, 1'b1);
    check("pin_drive", pin_drive, drive_ref);
    read_word({MAP_GPIO, GPIO_DRIVE_OFS}, drive_ref, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned cnt;
    req = '0;
    vld = 1'b0;
    pin_sense = '0;
    cnt = 0;
    while (arst_n !== 1'b1) begin
      @(posedge bus);
      cnt++;
      if (cnt > 32) report_timeout("reset release");
    end
    @(negedge bus);
    // reset state
    check("pin_drive", pin_drive, '0);
    check("rsp.rdt", rsp.rdt, '0);
    check("rsp.err", rsp.err, 1'b0);
    sram_round_trip();
    back_to_back();
    gpio_drive();
    gpio_sense();
    error_responses();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: tcb_sys.f
source/tcb_pkg.sv
source/tcb_dec.sv
source/tcb_sram.sv
source/tcb_gpio.sv
source/tcb_sys.sv
test/tcb_clk.sv
test/tcb_sys_tb.sv

// File: Bender.yml
package:
  name: tcb_sys

sources:
  # design
  - source/tcb_pkg.sv
  - source/tcb_dec.sv
  - source/tcb_sram.sv
  - source/tcb_gpio.sv
  - source/tcb_sys.sv
  # testbench
  - target: test
    files:
      - test/tcb_clk.sv
      - test/tcb_sys_tb.sv
